// File: Bender.yml
package:
  name: rv_pipe_cpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/pipe_ctrl_if.sv
      - verilog/pipe_reg.sv
      - verilog/fetch_stage.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/hazard_control.sv
      - verilog/rv_pipe_cpu.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rv_pipe_cpu.sv

// File: sources.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/pipe_ctrl_if.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_control.sv
verilog/rv_pipe_cpu.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_pipe_cpu.sv

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns = 20.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end
endmodule

// File: testbench/tb_rv_pipe_cpu.sv
`timescale 1ns/1ps

module tb_rv_pipe_cpu;

    typedef enum {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI,
        K_LUI, K_LW, K_SW, K_BEQ, K_BNE
    } kind_e;

    localparam int rand_len   = 70;              // setup plus random body
    localparam int loop_idx   = rand_len + 15;   // after the register dump
    localparam int max_cycles = 1200;            // 85 instructions at 12 cycles, rounded up

    logic        clk, rst;
    logic        read_a, resp_a, read_b, write_b, resp_b;
    logic [31:0] address_a, rdata_a, address_b, wdata_b, rdata_b;

    kind_e       p_kind [loop_idx + 1];
    logic [4:0]  p_rd [loop_idx + 1];
    logic [4:0]  p_rs1 [loop_idx + 1];
    logic [4:0]  p_rs2 [loop_idx + 1];
    logic [31:0] p_imm [loop_idx + 1];
    logic [31:0] imem [256];
    logic [31:0] dmem [128];
    logic [31:0] ref_mem [128];
    logic [31:0] ref_regs [16];
    logic [63:0] exp_stores [$];  // {address, data} in program order
    logic [31:0] lcg_state;
    logic        a_busy, b_busy, b_write, loop_seen;
    logic [31:0] b_addr;
    int          a_wait, b_wait, cycles;

    tb_clock_gen #(.period_ns(20.0)) i_clock_gen (.clk);

    rv_pipe_cpu i_rv_pipe_cpu (
        .clk, .rst, .read_a, .address_a, .resp_a, .rdata_a,
        .read_b, .write_b, .address_b, .wdata_b, .resp_b, .rdata_b
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0000, lcg_state[30:15]};  // low bits cycle too fast
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return ((32'(idx) << 2) * 32'h9e37_79b1) ^ 32'hc0de_0000;
    endfunction

    // RV32I base encodings
    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd, rs1, rs2,
                                           input logic [31:0] imm);
        logic [2:0]  f3;
        logic [31:0] w;
        case (k)
            K_ADD, K_SUB, K_ADDI, K_BEQ: f3 = 3'b000;
            K_BNE:                       f3 = 3'b001;
            K_SLT, K_SLTI, K_LW, K_SW:   f3 = 3'b010;
            K_XOR, K_XORI:               f3 = 3'b100;
            K_OR, K_ORI:                 f3 = 3'b110;
            default:                     f3 = 3'b111;
        endcase
        case (k)
            K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT:
                w = {1'b0, k == K_SUB, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            K_LUI: w = {imm[31:12], rd, 7'b0110111};
            K_LW:  w = {imm[11:0], rs1, f3, rd, 7'b0000011};
            K_SW:  w = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
            K_BEQ, K_BNE:
                w = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            default: w = {imm[11:0], rs1, f3, rd, 7'b0010011};
        endcase
        return w;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic build_program();
        kind_e       k;
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i <= loop_idx; i++) begin
            r        = lcg_next() % 20;
            k        = (r >= 18) ? K_SW : (r >= 16) ? K_LW : kind_e'(r);
            p_rd[i]  = 1 + lcg_next() % 15;
            p_rs1[i] = 1 + lcg_next() % 15;
            p_rs2[i] = (lcg_next() % 2) ? p_rs1[i] : 1 + lcg_next() % 15;
            r        = lcg_next();
            p_imm[i] = {{20{r[11]}}, r[11:0]};
            if (i < 15) begin
                k        = K_ADDI;  // x1..x15 get a defined value first
                p_rd[i]  = i + 1;
                p_rs1[i] = 0;
            end else if (i == loop_idx) begin
                k        = K_BEQ;  // self loop
                p_rs1[i] = 0;
                p_rs2[i] = 0;
                p_imm[i] = 0;
            end else if (i >= rand_len) begin
                k        = K_SW;  // register dump at 256 and up
                p_rs1[i] = 0;
                p_rs2[i] = i - rand_len + 1;
                p_imm[i] = 256 + 4 * (i - rand_len);
            end else if (k == K_LUI) begin
                p_imm[i] = {r[15:0], r[3:0], 12'h000};
            end else if (k == K_LW || k == K_SW) begin
                p_rs1[i] = 0;
                p_imm[i] = 4 * (r % 16);
            end else if (k == K_BEQ || k == K_BNE) begin
                p_imm[i] = 8;
                if (i == rand_len - 1) k = K_XORI;  // must not skip the first dump store
            end
            p_kind[i] = k;
            imem[i]   = encode(k, p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
        end
    endtask

    // one instruction at a time, straight from the ISA rules
    task automatic run_model();
        logic [31:0] a, b, imm, res;
        int          pc;
        pc = 0;
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 128; i++) begin
            ref_mem[i] = fill_word(i);
        end
        while (pc != loop_idx) begin
            a   = ref_regs[p_rs1[pc]];
            b   = ref_regs[p_rs2[pc]];
            imm = p_imm[pc];
            case (p_kind[pc])
                K_ADD:   res = a + b;
                K_SUB:   res = a - b;
                K_AND:   res = a & b;
                K_OR:    res = a | b;
                K_XOR:   res = a ^ b;
                K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI:  res = a + imm;
                K_ANDI:  res = a & imm;
                K_ORI:   res = a | imm;
                K_XORI:  res = a ^ imm;
                K_SLTI:  res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                K_LUI:   res = imm;
                K_LW:    res = ref_mem[(a + imm) >> 2];
                default: res = '0;
            endcase
            if (p_kind[pc] == K_SW) begin
                ref_mem[(a + imm) >> 2] = b;
                exp_stores.push_back({a + imm, b});
            end else if (p_kind[pc] < K_SW) begin
                ref_regs[p_rd[pc]] = res;
            end
            if ((p_kind[pc] == K_BEQ && a == b) || (p_kind[pc] == K_BNE && a != b)) begin
                pc += 2;  // +8 skips one
            end else begin
                pc += 1;
            end
        end
    endtask

    task automatic answer_fetch();
        if (read_a) begin
            if (!a_busy) begin
                a_busy = 1'b1;
                a_wait = lcg_next() % 4;
            end
            if (a_wait == 0) begin
                resp_a  = 1'b1;
                rdata_a = imem[address_a[9:2]];
                a_busy  = 1'b0;
                if (address_a == 4 * loop_idx) loop_seen = 1'b1;
            end else begin
                a_wait--;
            end
        end
    endtask

    task automatic answer_data();
        logic [63:0] exp;
        assert (!(read_b && write_b)) else
            report_failure("read_b and write_b were high in the same cycle");
        if (b_busy) begin  // request still open from an earlier cycle
            assert (read_b || write_b) else
                report_failure("data request dropped before resp_b");
            assert (address_b == b_addr) else
                report_failure($sformatf("Fail address_b: got 0x%08h, expected 0x%08h",
                                         address_b, b_addr));
            assert (write_b == b_write) else
                report_failure("data request switched between read and write");
        end
        if (read_b || write_b) begin
            if (!b_busy) begin
                b_busy  = 1'b1;
                b_addr  = address_b;
                b_write = write_b;
                b_wait  = lcg_next() % 4;
            end
            if (b_wait == 0) begin
                resp_b = 1'b1;
                b_busy = 1'b0;
                if (write_b) begin
                    assert (exp_stores.size() > 0) else
                        report_failure($sformatf("store to 0x%08h after the last expected one",
                                                 address_b));
                    exp = exp_stores.pop_front();
                    assert (address_b == exp[63:32]) else
                        report_failure($sformatf("Fail address_b: got 0x%08h, expected 0x%08h",
                                                 address_b, exp[63:32]));
                    assert (wdata_b == exp[31:0]) else
                        report_failure($sformatf("Fail wdata_b: got 0x%08h, expected 0x%08h",
                                                 wdata_b, exp[31:0]));
                    dmem[address_b[8:2]] = wdata_b;
                end else begin
                    rdata_b = dmem[address_b[8:2]];
                end
            end else begin
                b_wait--;
            end
        end
    endtask

    // both memories answer 1 ns after the edge, after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        resp_a = 1'b0;
        resp_b = 1'b0;
        if (!rst) begin
            answer_fetch();
            answer_data();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            report_failure("timeout: the program never reached its final loop");
        end
    end

    initial begin
        rst       = 1'b1;
        resp_a    = 1'b0;
        rdata_a   = '0;
        resp_b    = 1'b0;
        rdata_b   = '0;
        lcg_state = 32'h9551;
        cycles    = 0;
        a_busy    = 1'b0;
        b_busy    = 1'b0;
        b_write   = 1'b0;
        b_addr    = '0;
        a_wait    = 0;
        b_wait    = 0;
        loop_seen = 1'b0;
        for (int i = 0; i < 128; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        run_model();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        while (!(loop_seen && exp_stores.size() == 0)) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // a stray store now hits the empty list
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::if_id_t  id_in,
    input  logic            id_valid,
    input  rv_pkg::mem_wb_t wb_in,
    input  logic            wb_valid,
    output rv_pkg::id_ex_t  id_out
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] ins;
    logic                wb_we;
    ctrl_word_t          c;

    assign ins   = id_in.instr;
    assign wb_we = wb_valid & wb_in.reg_write & (wb_in.rd != 5'd0) & ~rst;

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_in.rd] <= wb_in.result;
        end
    end

    always_comb begin
        c           = '0;
        c.rs1       = ins[19:15];
        c.rs2       = ins[24:20];
        c.rd        = ins[11:7];
        c.alu_op    = ALU_ADD;
        c.wb_sel    = WB_ALU;
        case (opcode_e'(ins[6:0]))
            OPC_OP, OPC_OP_IMM: begin
                c.use_imm   = (ins[6:0] == OPC_OP_IMM);
                c.imm       = {{20{ins[31]}}, ins[31:20]};
                c.reg_write = 1'b1;
                if (c.use_imm) c.rs2 = 5'd0;
                case (ins[14:12])
                    3'b000: c.alu_op = (!c.use_imm && ins[30]) ? ALU_SUB : ALU_ADD;
                    3'b010: c.alu_op = ALU_SLT;
                    3'b100: c.alu_op = ALU_XOR;
                    3'b110: c.alu_op = ALU_OR;
                    3'b111: c.alu_op = ALU_AND;
                    default: c.reg_write = 1'b0;  // shifts, sltu not built
                endcase
            end
            OPC_LUI: begin
                c.is_lui    = 1'b1;
                c.imm       = {ins[31:12], 12'b0};
                c.rs1       = 5'd0;
                c.rs2       = 5'd0;
                c.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                c.use_imm   = 1'b1;
                c.imm       = {{20{ins[31]}}, ins[31:20]};
                c.rs2       = 5'd0;
                c.mem_read  = 1'b1;
                c.reg_write = 1'b1;
                c.wb_sel    = WB_LOAD;
            end
            OPC_STORE: begin
                c.use_imm   = 1'b1;
                c.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                c.rd        = 5'd0;
                c.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                c.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                c.rd        = 5'd0;
                c.is_branch = 1'b1;
                c.branch_ne = ins[12];
            end
            default: c.rd = 5'd0;  // unknown opcode, nothing written
        endcase
        if (!id_valid) begin
            c.reg_write = 1'b0;
            c.mem_read  = 1'b0;
            c.mem_write = 1'b0;
            c.is_branch = 1'b0;
        end
    end

    // x0 reads zero, wb write shows through in the same cycle
    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [4:0] idx);
        logic [`RV_XLEN-1:0] val;
        if (idx == 5'd0) val = '0;
        else if (wb_we && wb_in.rd == idx) val = wb_in.result;
        else val = regs[idx];
        return val;
    endfunction

    always_comb begin
        id_out.ctrl    = c;
        id_out.pc      = id_in.pc;
        id_out.rs1_val = rf_read(c.rs1);
        id_out.rs2_val = rf_read(c.rs2);
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_stage (
    input  rv_pkg::id_ex_t      ex_in,
    input  logic                ex_valid,
    input  rv_pkg::ex_mem_t     mem_fwd,
    input  logic                mem_fwd_valid,
    input  rv_pkg::mem_wb_t     wb_fwd,
    input  logic                wb_fwd_valid,
    output rv_pkg::ex_mem_t     ex_out,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,
    output logic                load_use
);
    import rv_pkg::*;

    ctrl_word_t          c;
    logic                mem_hit1, mem_hit2, wb_hit1, wb_hit2;
    logic [`RV_XLEN-1:0] rs1_fwd, rs2_fwd, op_b, alu_out;
    logic                taken;

    assign c = ex_in.ctrl;

    assign mem_hit1 = mem_fwd_valid & mem_fwd.reg_write & (c.rs1 != 5'd0)
                      & (mem_fwd.rd == c.rs1);
    assign mem_hit2 = mem_fwd_valid & mem_fwd.reg_write & (c.rs2 != 5'd0)
                      & (mem_fwd.rd == c.rs2);
    assign wb_hit1  = wb_fwd_valid & wb_fwd.reg_write & (c.rs1 != 5'd0)
                      & (wb_fwd.rd == c.rs1);
    assign wb_hit2  = wb_fwd_valid & wb_fwd.reg_write & (c.rs2 != 5'd0)
                      & (wb_fwd.rd == c.rs2);

    // load in mem has no data yet
    assign load_use = ex_valid & mem_fwd.mem_read & (mem_hit1 | mem_hit2);

    assign rs1_fwd = mem_hit1 ? mem_fwd.alu_out : wb_hit1 ? wb_fwd.result : ex_in.rs1_val;
    assign rs2_fwd = mem_hit2 ? mem_fwd.alu_out : wb_hit2 ? wb_fwd.result : ex_in.rs2_val;
    assign op_b    = c.use_imm ? c.imm : rs2_fwd;

    always_comb begin
        case (c.alu_op)
            ALU_SUB: alu_out = rs1_fwd - op_b;
            ALU_AND: alu_out = rs1_fwd & op_b;
            ALU_OR:  alu_out = rs1_fwd | op_b;
            ALU_XOR: alu_out = rs1_fwd ^ op_b;
            ALU_SLT: alu_out = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            default: alu_out = rs1_fwd + op_b;
        endcase
        if (c.is_lui) alu_out = c.imm;
    end

    assign taken = c.is_branch & ((rs1_fwd == rs2_fwd) ^ c.branch_ne);

    // on load-use the consumer is squashed and fetched again
    assign redirect    = ex_valid & (load_use | taken);
    assign redirect_pc = load_use ? ex_in.pc : ex_in.pc + c.imm;

    assign ex_out.rd         = c.rd;
    assign ex_out.reg_write  = c.reg_write & ex_valid & ~load_use;
    assign ex_out.mem_read   = c.mem_read & ex_valid & ~load_use;
    assign ex_out.mem_write  = c.mem_write & ex_valid & ~load_use;
    assign ex_out.wb_sel     = c.wb_sel;
    assign ex_out.alu_out    = alu_out;
    assign ex_out.store_data = rs2_fwd;

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                rst,
    pipe_ctrl_if.stage          ctrl,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic                read_a,
    output logic [`RV_XLEN-1:0] address_a,
    input  logic                resp_a,
    input  logic [`RV_XLEN-1:0] rdata_a,
    output rv_pkg::if_id_t      if_out,
    output logic                if_valid
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pend_pc;  // redirect target waiting for the open fetch
    logic                pend;
    logic                fetch_en;
    logic                take_redir;

    assign take_redir = redirect & ctrl.mem_load;  // ex frozen means branch retries

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `RV_RESET_PC;
            pend     <= 1'b0;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (resp_a) begin
                pend <= 1'b0;
                if (take_redir) begin
                    pc <= redirect_pc;
                end else if (pend) begin
                    pc <= pend_pc;  // stale fetch dropped
                end else if (ctrl.pc_load) begin
                    pc <= pc + `RV_XLEN'd4;
                end
            end else if (take_redir) begin
                pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_redir) begin
            pend_pc <= redirect_pc;
        end
    end

    assign read_a      = fetch_en;
    assign address_a   = pc;
    assign if_out.pc   = pc;
    assign if_out.instr = rdata_a;
    assign if_valid    = resp_a & ~pend & ~take_redir;

    // the flush behind a redirect leaves ex empty until the stale fetch returns
    a_single_redirect: assert property (@(posedge clk) disable iff (rst)
        pend |-> !redirect);

endmodule

// File: verilog/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
    pipe_ctrl_if.ctrl ctrl,
    input  logic      read_a,
    input  logic      resp_a,
    input  logic      mem_busy,
    input  logic      load_use,
    input  logic      redirect
);

    always_comb begin
        ctrl.pc_load  = 1'b1;
        ctrl.id_load  = 1'b1;
        ctrl.ex_load  = 1'b1;
        ctrl.mem_load = 1'b1;
        ctrl.wb_load  = 1'b1;
        ctrl.id_flush = 1'b0;
        ctrl.ex_flush = 1'b0;
        if (mem_busy) begin
            // whole pipe waits, wb kept so ex forwarding survives
            ctrl.pc_load  = 1'b0;
            ctrl.id_load  = 1'b0;
            ctrl.ex_load  = 1'b0;
            ctrl.mem_load = 1'b0;
            ctrl.wb_load  = 1'b0;
        end else if (redirect || load_use) begin
            ctrl.id_flush = 1'b1;  // two younger instructions dropped
            ctrl.ex_flush = 1'b1;
        end else if (read_a && !resp_a) begin
            ctrl.pc_load  = 1'b0;
            ctrl.id_load  = 1'b0;
            ctrl.ex_flush = 1'b1;
        end
    end

    // a branch caught behind a data wait stays in ex until the wait ends
    a_wait_no_flush: assert property (@(posedge ctrl.clk)
        mem_busy && redirect |=> redirect);

endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic            clk,
    input  logic            rst,
    pipe_ctrl_if.stage      ctrl,
    input  rv_pkg::ex_mem_t mem_in,
    input  logic            mem_valid,
    output logic            read_b,
    output logic            write_b,
    output logic [31:0]     address_b,
    output logic [31:0]     wdata_b,
    input  logic            resp_b,
    input  logic [31:0]     rdata_b,
    output rv_pkg::mem_wb_t mem_out,
    output logic            mem_busy
);
    import rv_pkg::*;

    logic        req;

    assign req       = mem_valid & (mem_in.mem_read | mem_in.mem_write);
    assign read_b    = req & mem_in.mem_read;
    assign write_b   = req & mem_in.mem_write;
    assign address_b = mem_in.alu_out;
    assign wdata_b   = mem_in.store_data;
    assign mem_busy  = req & ~resp_b;

    assign mem_out.rd        = mem_in.rd;
    assign mem_out.reg_write = mem_in.reg_write & mem_valid;
    assign mem_out.result    = (mem_in.wb_sel == WB_LOAD) ? rdata_b : mem_in.alu_out;

    a_rw_excl: assert property (@(posedge clk) disable iff (rst) !(read_b && write_b));

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (read_b || write_b) && !resp_b |=> $stable(address_b) && $stable(wdata_b)
        && (read_b || write_b));

    // an open access holds ex/mem in place
    a_wait_freezes: assert property (@(posedge clk) disable iff (rst)
        mem_busy |-> !ctrl.mem_load);

endmodule

// File: verilog/pipe_ctrl_if.sv
`timescale 1ns/1ps

interface pipe_ctrl_if (input logic clk);
    // freeze levels, low holds the register
    logic pc_load;
    logic id_load;
    logic ex_load;
    logic mem_load;
    logic wb_load;
    // bubble insertion
    logic id_flush;
    logic ex_flush;

    modport ctrl (input clk, output pc_load, id_load, ex_load, mem_load, wb_load,
                  id_flush, ex_flush);
    modport stage (input clk, input pc_load, id_load, ex_load, mem_load, wb_load,
                   id_flush, ex_flush);
endinterface

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = rv_pkg::mem_wb_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     flush,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q_valid <= 1'b0;
        end else if (load) begin
            q_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            q <= d;
        end
    end

    // a frozen stage keeps its instruction intact
    a_hold_on_freeze: assert property (@(posedge clk) disable iff (rst)
        q_valid && !load |-> !flush);

endmodule

// File: verilog/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: verilog/rv_pipe_cpu.sv
`timescale 1ns/1ps

module rv_pipe_cpu (
    input  logic        clk,
    input  logic        rst,
    // instruction port
    output logic        read_a,
    output logic [31:0] address_a,
    input  logic        resp_a,
    input  logic [31:0] rdata_a,
    // data port
    output logic        read_b,
    output logic        write_b,
    output logic [31:0] address_b,
    output logic [31:0] wdata_b,
    input  logic        resp_b,
    input  logic [31:0] rdata_b
);
    import rv_pkg::*;

    if_id_t      if_d, if_q;
    id_ex_t      id_d, id_q;
    ex_mem_t     ex_d, ex_q;
    mem_wb_t     mem_d, wb_q;
    logic        if_valid, id_valid, ex_valid, mem_valid, wb_valid;
    logic        redirect, load_use, mem_busy;
    logic [31:0] redirect_pc;

    pipe_ctrl_if ctrl_if (.clk);

    hazard_control i_hazard (.ctrl(ctrl_if.ctrl), .read_a, .resp_a, .mem_busy,
                             .load_use, .redirect);

    fetch_stage i_fetch (.clk, .rst, .ctrl(ctrl_if.stage), .redirect, .redirect_pc,
                         .read_a, .address_a, .resp_a, .rdata_a,
                         .if_out(if_d), .if_valid);

    pipe_reg #(.payload_t(if_id_t)) i_if_id (.clk, .rst, .load(ctrl_if.id_load),
        .flush(ctrl_if.id_flush), .d(if_d), .d_valid(if_valid), .q(if_q), .q_valid(id_valid));

    decode_stage i_decode (.clk, .rst, .id_in(if_q), .id_valid, .wb_in(wb_q), .wb_valid,
                           .id_out(id_d));

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (.clk, .rst, .load(ctrl_if.ex_load),
        .flush(ctrl_if.ex_flush), .d(id_d), .d_valid(id_valid), .q(id_q), .q_valid(ex_valid));

    execute_stage i_execute (.ex_in(id_q), .ex_valid, .mem_fwd(ex_q),
                             .mem_fwd_valid(mem_valid), .wb_fwd(wb_q), .wb_fwd_valid(wb_valid),
                             .ex_out(ex_d), .redirect, .redirect_pc, .load_use);

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (.clk, .rst, .load(ctrl_if.mem_load),
        .flush(1'b0), .d(ex_d), .d_valid(ex_valid), .q(ex_q), .q_valid(mem_valid));

    memory_stage i_memory (.clk, .rst, .ctrl(ctrl_if.stage), .mem_in(ex_q), .mem_valid,
                           .read_b, .write_b, .address_b, .wdata_b, .resp_b, .rdata_b,
                           .mem_out(mem_d), .mem_busy);

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (.clk, .rst, .load(ctrl_if.wb_load),
        .flush(1'b0), .d(mem_d), .d_valid(mem_valid), .q(wb_q), .q_valid(wb_valid));

endmodule

// File: verilog/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_sel_e;

    typedef struct packed {
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        alu_op_e               alu_op;
        logic [`RV_XLEN-1:0]   imm;
        logic                  use_imm;
        logic                  is_lui;
        logic                  mem_read;
        logic                  mem_write;
        logic                  is_branch;
        logic                  branch_ne;  // bne when set, beq otherwise
        logic                  reg_write;
        wb_sel_e               wb_sel;
    } ctrl_word_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t          ctrl;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        wb_sel_e             wb_sel;
        logic [`RV_XLEN-1:0] alu_out;
        logic [`RV_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic                reg_write;
        logic [`RV_XLEN-1:0] result;
    } mem_wb_t;

endpackage
